// File: Makefile
# Verilator build and run of the GEMM configuration front end testbench

VERILATOR ?= verilator
TOP       ?= gemm_cfg_tb
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -Wno-fatal

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS"

$(BUILD_DIR)/V$(TOP): $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)

// File: all.f
+incdir+logic
logic/gemm_cfg_pkg.sv
logic/gemm_seq_mult.sv
logic/gemm_tiler.sv
logic/gemm_cfg_regfile.sv
logic/gemm_cfg_top.sv
tb/gemm_cfg_properties.sv
tb/gemm_cfg_tb.sv

// File: logic/gemm_cfg_defines.svh
// Array geometry and register map of the GEMM configuration front end, included by the RTL and TB
`ifndef GEMM_CFG_DEFINES_SVH
`define GEMM_CFG_DEFINES_SVH

// Systolic array geometry
`define GEMM_ARRAY_WIDTH  12
`define GEMM_ARRAY_HEIGHT 4
`define GEMM_PIPE_REGS    3
// Columns covered by one tile
`define GEMM_TILE_DEPTH   (`GEMM_ARRAY_HEIGHT * (`GEMM_PIPE_REGS + 1))
`define GEMM_ELEM_BYTES   2

// AXI4-Lite address width
`define GEMM_AXIL_AW 8

// Register indices, taken from address bits 5 to 2
`define GEMM_REG_X_ADDR      4'd0
`define GEMM_REG_W_ADDR      4'd1
`define GEMM_REG_Z_ADDR      4'd2
`define GEMM_REG_MCFG0       4'd3
`define GEMM_REG_MCFG1       4'd4
`define GEMM_REG_MACFG       4'd5
`define GEMM_REG_TRIGGER     4'd6
`define GEMM_REG_STATUS      4'd7
`define GEMM_REG_X_ITERS     4'd8
`define GEMM_REG_W_ITERS     4'd9
`define GEMM_REG_LEFTOVERS   4'd10
`define GEMM_REG_TOT_STORES  4'd11
`define GEMM_REG_X_D1_STRIDE 4'd12
`define GEMM_REG_W_TOT_LEN   4'd13
`define GEMM_REG_TOT_X_READ  4'd14
`define GEMM_REG_OP_SEL      4'd15

`endif

// File: logic/gemm_cfg_pkg.sv
// Shared widths, encodings and bus records of the GEMM configuration front end, for RTL and TB
`default_nettype none

`include "gemm_cfg_defines.svh"

package gemm_cfg_pkg;

  // Widths with a meaning
  typedef logic [31:0] word_t;
  typedef logic [15:0] dim_t;
  typedef logic [15:0] iter_t;
  typedef logic [7:0]  lftovr_t;
  typedef logic [3:0]  reg_idx_t;

  typedef logic [`GEMM_AXIL_AW-1:0] axil_addr_t;
  typedef logic [$bits(word_t)/8-1:0] axil_strb_t;
  typedef logic [1:0] axil_resp_t;

  localparam axil_resp_t axil_resp_okay = 2'b00;

  // Job encodings as written by the host
  typedef enum logic [2:0] {MATMUL, GEMM, ADDMAX, ADDMIN, MULMAX, MULMIN, MAXMIN} gemm_op_e;
  typedef enum logic [2:0] {FLOAT16, FLOAT8, FLOAT16ALT, FLOAT8ALT} gemm_fmt_e;

  // FPU side encodings
  typedef enum logic [2:0] {RNE = 3'd0, RTZ = 3'd1} rnd_mode_e;
  typedef enum logic [4:0] {
    FPU_FMADD  = 5'd0,
    FPU_ADD    = 5'd2,
    FPU_MUL    = 5'd3,
    FPU_MINMAX = 5'd7
  } fpu_op_e;

  typedef enum logic [1:0] {IDLE, MUL1, MUL2, DONE} tiler_state_e;

  typedef struct packed {
    logic       aw_valid;
    axil_addr_t aw_addr;
    logic       w_valid;
    word_t      w_data;
    axil_strb_t w_strb;
    logic       b_ready;
    logic       ar_valid;
    axil_addr_t ar_addr;
    logic       r_ready;
  } axil_req_t;

  typedef struct packed {
    logic       aw_ready;
    logic       w_ready;
    logic       b_valid;
    axil_resp_t b_resp;
    logic       ar_ready;
    logic       r_valid;
    word_t      r_data;
    axil_resp_t r_resp;
  } axil_rsp_t;

  typedef struct packed {
    dim_t      m;
    dim_t      n;
    dim_t      k;
    gemm_op_e  op;
    gemm_fmt_e fmt;
  } tiler_cfg_t;

  // Result words, in register order from X_ITERS up
  typedef struct packed {
    word_t x_iters;
    word_t w_iters;
    word_t leftovers;
    word_t tot_stores;
    word_t x_d1_stride;
    word_t w_tot_len;
    word_t tot_x_read;
    word_t op_sel;
  } tiler_res_t;

endpackage

`default_nettype wire

// File: logic/gemm_cfg_regfile.sv
// AXI4-Lite register file of the GEMM front end with job, trigger, status and tiler result regs
`default_nettype none

`include "gemm_cfg_defines.svh"

module gemm_cfg_regfile
  import gemm_cfg_pkg::*;
(
  input  logic       clk_int,
  input  logic       rst_ni,
  input  axil_req_t  axil_req_i,
  output axil_rsp_t  axil_rsp_o,
  output logic       start_o,
  output tiler_cfg_t cfg_o,
  input  logic       valid_i,
  input  tiler_res_t res_i
);

  // Job registers sit below the trigger index
  word_t    job_q [`GEMM_REG_TRIGGER];

  reg_idx_t wr_idx;
  reg_idx_t rd_idx;
  logic     wr_en;
  logic     rd_en;
  logic     trigger;
  logic     bvalid_q;
  logic     rvalid_q;
  word_t    rdata_d;
  word_t    rdata_q;
  logic     start_q;
  logic     busy_q;
  logic     done_q;

  // Only bits 5 to 2 select a register
  assign wr_idx = axil_req_i.aw_addr[5:2];
  assign rd_idx = axil_req_i.ar_addr[5:2];

  // Address and data are taken together, once no write response is pending
  assign wr_en = axil_req_i.aw_valid && axil_req_i.w_valid && !bvalid_q;
  assign rd_en = axil_req_i.ar_valid && !rvalid_q;

  assign trigger = wr_en && (wr_idx == `GEMM_REG_TRIGGER) &&
                   axil_req_i.w_strb[0] && axil_req_i.w_data[0];

  always_ff @(posedge clk_int or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int r = 0; r < `GEMM_REG_TRIGGER; r++) begin
        job_q[r] <= '0;
      end
    end else if (wr_en && (wr_idx < `GEMM_REG_TRIGGER)) begin
      for (int b = 0; b < $bits(axil_strb_t); b++) begin
        if (axil_req_i.w_strb[b]) begin
          job_q[wr_idx[2:0]][8*b +: 8] <= axil_req_i.w_data[8*b +: 8];
        end
      end
    end
  end

  // Write response held until the host takes it
  always_ff @(posedge clk_int or negedge rst_ni) begin
    if (!rst_ni) begin
      bvalid_q <= 1'b0;
    end else if (wr_en) begin
      bvalid_q <= 1'b1;
    end else if (axil_req_i.b_ready) begin
      bvalid_q <= 1'b0;
    end
  end

  // Trigger while busy is dropped
  always_ff @(posedge clk_int or negedge rst_ni) begin
    if (!rst_ni) begin
      start_q <= 1'b0;
      busy_q  <= 1'b0;
      done_q  <= 1'b0;
    end else begin
      start_q <= trigger && !busy_q;
      if (trigger && !busy_q) begin
        busy_q <= 1'b1;
        done_q <= 1'b0;
      end else if (valid_i) begin
        busy_q <= 1'b0;
        done_q <= 1'b1;
      end
    end
  end

  // Read mux, the trigger reads as zero
  always_comb begin
    rdata_d = '0;
    if (rd_idx < `GEMM_REG_TRIGGER) begin
      rdata_d = job_q[rd_idx[2:0]];
    end else begin
      case (rd_idx)
        `GEMM_REG_STATUS:      rdata_d = {30'b0, done_q, busy_q};
        `GEMM_REG_X_ITERS:     rdata_d = res_i.x_iters;
        `GEMM_REG_W_ITERS:     rdata_d = res_i.w_iters;
        `GEMM_REG_LEFTOVERS:   rdata_d = res_i.leftovers;
        `GEMM_REG_TOT_STORES:  rdata_d = res_i.tot_stores;
        `GEMM_REG_X_D1_STRIDE: rdata_d = res_i.x_d1_stride;
        `GEMM_REG_W_TOT_LEN:   rdata_d = res_i.w_tot_len;
        `GEMM_REG_TOT_X_READ:  rdata_d = res_i.tot_x_read;
        `GEMM_REG_OP_SEL:      rdata_d = res_i.op_sel;
        default:               rdata_d = '0;
      endcase
    end
  end

  always_ff @(posedge clk_int or negedge rst_ni) begin
    if (!rst_ni) begin
      rvalid_q <= 1'b0;
    end else if (rd_en) begin
      rvalid_q <= 1'b1;
    end else if (axil_req_i.r_ready) begin
      rvalid_q <= 1'b0;
    end
  end

  // Read data stays put while rvalid waits for rready
  always_ff @(posedge clk_int) begin
    if (rd_en) begin
      rdata_q <= rdata_d;
    end
  end

  assign axil_rsp_o.aw_ready = wr_en;
  assign axil_rsp_o.w_ready  = wr_en;
  assign axil_rsp_o.b_valid  = bvalid_q;
  assign axil_rsp_o.b_resp   = axil_resp_okay;
  assign axil_rsp_o.ar_ready = !rvalid_q;
  assign axil_rsp_o.r_valid  = rvalid_q;
  assign axil_rsp_o.r_data   = rdata_q;
  assign axil_rsp_o.r_resp   = axil_resp_okay;

  // MCFG0 has K on top of M, MACFG has op in 12:10 and format in 9:7
  assign cfg_o.m   = job_q[3'(`GEMM_REG_MCFG0)][15:0];
  assign cfg_o.k   = job_q[3'(`GEMM_REG_MCFG0)][31:16];
  assign cfg_o.n   = job_q[3'(`GEMM_REG_MCFG1)][15:0];
  assign cfg_o.op  = gemm_op_e'(job_q[3'(`GEMM_REG_MACFG)][12:10]);
  assign cfg_o.fmt = gemm_fmt_e'(job_q[3'(`GEMM_REG_MACFG)][9:7]);

  assign start_o = start_q;

endmodule

`default_nettype wire

// File: logic/gemm_cfg_top.sv
// Top level of the GEMM configuration front end, the AXI4-Lite register file feeding the tiler
`default_nettype none

module gemm_cfg_top
  import gemm_cfg_pkg::*;
(
  input  logic      clk_int,
  input  logic      rst_ni,
  input  axil_req_t axil_req_i,
  output axil_rsp_t axil_rsp_o
);

  logic       tiler_start;
  tiler_cfg_t tiler_cfg;
  logic       tiler_valid;
  tiler_res_t tiler_res;

  // Host side and job registers
  gemm_cfg_regfile i_regfile (
    .clk_int    (clk_int),
    .rst_ni     (rst_ni),
    .axil_req_i (axil_req_i),
    .axil_rsp_o (axil_rsp_o),
    .start_o    (tiler_start),
    .cfg_o      (tiler_cfg),
    .valid_i    (tiler_valid),
    .res_i      (tiler_res)
  );

  // Tiling arithmetic
  gemm_tiler i_tiler (
    .clk_int (clk_int),
    .rst_ni  (rst_ni),
    .start_i (tiler_start),
    .cfg_i   (tiler_cfg),
    .valid_o (tiler_valid),
    .res_o   (tiler_res)
  );

endmodule

`default_nettype wire

// File: logic/gemm_seq_mult.sv
// Sequential shift-add multiplier of the tiler, one bit of the first operand per clock cycle
`default_nettype none

module gemm_seq_mult
  import gemm_cfg_pkg::*;
(
  input  logic  clk_int,
  input  logic  rst_ni,
  input  logic  start_i,
  input  iter_t a_i,
  input  word_t b_i,
  output logic  valid_o,
  output word_t prod_o
);

  localparam int unsigned steps = $bits(iter_t);
  localparam int unsigned cnt_w = $clog2(steps);
  localparam logic [cnt_w-1:0] last_cnt = cnt_w'(steps - 1);

  logic             run_q;
  logic             valid_q;
  logic [cnt_w-1:0] cnt_q;
  logic             last_step;
  iter_t            a_q;
  word_t            b_q;
  word_t            acc_q;

  // Bit 0 is consumed at the start edge, the other 15 afterwards
  assign last_step = run_q && (cnt_q == last_cnt);

  always_ff @(posedge clk_int or negedge rst_ni) begin
    if (!rst_ni) begin
      run_q   <= 1'b0;
      valid_q <= 1'b0;
      cnt_q   <= '0;
    end else begin
      valid_q <= last_step;
      if (start_i) begin
        run_q <= 1'b1;
        cnt_q <= cnt_w'(1);
      end else if (run_q) begin
        cnt_q <= cnt_q + 1'b1;
        if (last_step) begin
          run_q <= 1'b0;
        end
      end
    end
  end

  always_ff @(posedge clk_int) begin
    if (start_i) begin
      a_q   <= a_i >> 1;
      b_q   <= b_i << 1;
      acc_q <= a_i[0] ? b_i : '0;
    end else if (run_q) begin
      if (a_q[0]) begin
        acc_q <= acc_q + b_q;
      end
      a_q <= a_q >> 1;
      b_q <= b_q << 1;
    end
  end

  assign valid_o = valid_q;
  // Low 32 bits of the product, held until the next start
  assign prod_o  = acc_q;

endmodule

`default_nettype wire

// File: logic/gemm_tiler.sv
// Job tiler that splits a GEMM job into array tiles and registers the result record for the host
`default_nettype none

`include "gemm_cfg_defines.svh"

module gemm_tiler
  import gemm_cfg_pkg::*;
(
  input  logic       clk_int,
  input  logic       rst_ni,
  input  logic       start_i,
  input  tiler_cfg_t cfg_i,
  output logic       valid_o,
  output tiler_res_t res_o
);

  tiler_state_e state_q;
  tiler_state_e state_d;
  tiler_cfg_t   cfg_q;
  tiler_res_t   res_d;
  tiler_res_t   res_q;

  logic    mul1_start_q;
  logic    mul1_valid;
  logic    mul2_start;
  logic    xcols_valid;
  logic    wrows_valid;
  logic    res_load;
  word_t   rows_by_cols;
  word_t   tot_x_read;
  word_t   w_tot_len;

  iter_t   x_rows_iter;
  iter_t   x_cols_iter;
  iter_t   w_rows_iter;
  iter_t   w_cols_iter;
  lftovr_t x_rows_lftovr;
  lftovr_t x_cols_lftovr;
  lftovr_t w_rows_lftovr;
  lftovr_t w_cols_lftovr;
  word_t   x_d1_stride;

  rnd_mode_e stage1_rnd;
  rnd_mode_e stage2_rnd;
  fpu_op_e   stage1_op;
  logic      gemm_sel;

  // Job captured on start, everything below derives from it
  always_ff @(posedge clk_int) begin
    if (state_q == IDLE && start_i) begin
      cfg_q <= cfg_i;
    end
  end

  assign x_rows_lftovr = lftovr_t'(cfg_q.m % dim_t'(`GEMM_ARRAY_WIDTH));
  assign x_cols_lftovr = lftovr_t'(cfg_q.n % dim_t'(`GEMM_TILE_DEPTH));
  assign w_cols_lftovr = lftovr_t'(cfg_q.k % dim_t'(`GEMM_TILE_DEPTH));
  assign w_rows_lftovr = lftovr_t'(cfg_q.n % dim_t'(`GEMM_ARRAY_HEIGHT));

  // Round up when a partial tile is left over
  assign x_rows_iter = cfg_q.m / dim_t'(`GEMM_ARRAY_WIDTH) + iter_t'(x_rows_lftovr != '0);
  assign x_cols_iter = cfg_q.n / dim_t'(`GEMM_TILE_DEPTH) + iter_t'(x_cols_lftovr != '0);
  assign w_cols_iter = cfg_q.k / dim_t'(`GEMM_TILE_DEPTH) + iter_t'(w_cols_lftovr != '0);
  // N padded up to a whole number of array rows
  assign w_rows_iter = cfg_q.n + ((w_rows_lftovr != '0) ?
                       (iter_t'(`GEMM_ARRAY_HEIGHT) - iter_t'(w_rows_lftovr)) : '0);

  assign x_d1_stride = word_t'(cfg_q.n) * word_t'(`GEMM_ELEM_BYTES);

  always_comb begin
    stage1_rnd = RNE;
    stage2_rnd = RNE;
    stage1_op  = FPU_MINMAX;
    case (cfg_q.op)
      MATMUL, GEMM: stage1_op = FPU_FMADD;
      ADDMAX: begin
        stage1_op  = FPU_ADD;
        stage2_rnd = RTZ;
      end
      ADDMIN: stage1_op = FPU_ADD;
      MULMAX: begin
        stage1_op  = FPU_MUL;
        stage2_rnd = RTZ;
      end
      MULMIN: stage1_op = FPU_MUL;
      MAXMIN: stage1_rnd = RTZ;
      default: stage1_op = FPU_MINMAX;
    endcase
  end

  assign gemm_sel = (cfg_q.op != MATMUL);

  // First stage, x_rows_iter times w_cols_iter
  gemm_seq_mult i_rows_by_cols (
    .clk_int (clk_int),
    .rst_ni  (rst_ni),
    .start_i (mul1_start_q),
    .a_i     (x_rows_iter),
    .b_i     (word_t'(w_cols_iter)),
    .valid_o (mul1_valid),
    .prod_o  (rows_by_cols)
  );

  // Second stage, both products reuse the first one
  gemm_seq_mult i_by_x_cols (
    .clk_int (clk_int),
    .rst_ni  (rst_ni),
    .start_i (mul2_start),
    .a_i     (x_cols_iter),
    .b_i     (rows_by_cols),
    .valid_o (xcols_valid),
    .prod_o  (tot_x_read)
  );

  gemm_seq_mult i_by_w_rows (
    .clk_int (clk_int),
    .rst_ni  (rst_ni),
    .start_i (mul2_start),
    .a_i     (w_rows_iter),
    .b_i     (rows_by_cols),
    .valid_o (wrows_valid),
    .prod_o  (w_tot_len)
  );

  assign mul2_start = (state_q == MUL1) && mul1_valid;
  assign res_load   = (state_q == MUL2) && xcols_valid && wrows_valid;

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE: if (start_i) state_d = MUL1;
      MUL1: if (mul1_valid) state_d = MUL2;
      MUL2: if (xcols_valid && wrows_valid) state_d = DONE;
      DONE: state_d = IDLE;
      default: state_d = IDLE;
    endcase
  end

  always_comb begin
    res_d.x_iters     = {x_rows_iter, x_cols_iter};
    res_d.w_iters     = {w_rows_iter, w_cols_iter};
    res_d.leftovers   = {x_rows_lftovr, x_cols_lftovr, w_rows_lftovr, w_cols_lftovr};
    res_d.tot_stores  = {rows_by_cols[15:0], 16'b0};
    res_d.x_d1_stride = x_d1_stride;
    res_d.w_tot_len   = w_tot_len;
    res_d.tot_x_read  = tot_x_read;
    res_d.op_sel      = {stage1_rnd, stage2_rnd, stage1_op, FPU_MINMAX,
                         cfg_q.fmt, cfg_q.fmt, 9'b0, gemm_sel};
  end

  always_ff @(posedge clk_int or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q      <= IDLE;
      mul1_start_q <= 1'b0;
      res_q        <= '0;
    end else begin
      state_q      <= state_d;
      mul1_start_q <= (state_q == IDLE) && start_i;
      if (res_load) begin
        res_q <= res_d;
      end
    end
  end

  assign valid_o = (state_q == DONE);
  assign res_o   = res_q;

endmodule

`default_nettype wire

// File: tb/gemm_cfg_properties.sv
// Handshake and tiler valid assertions, bound into the register file by the testbench
`default_nettype none

module gemm_cfg_properties
  import gemm_cfg_pkg::*;
(
  input logic      clk_int,
  input logic      rst_ni,
  input axil_req_t req_i,
  input axil_rsp_t rsp_i,
  input logic      tiler_valid_i,
  input logic      busy_i
);

  timeunit 1ns;
  timeprecision 1ps;

  // Write response stays up until the host takes it
  bvalid_held: assert property (@(posedge clk_int) disable iff (!rst_ni)
    rsp_i.b_valid && !req_i.b_ready |=> rsp_i.b_valid)
    else $error("bvalid dropped before bready");

  // Read response and its data stay put until rready
  rvalid_held: assert property (@(posedge clk_int) disable iff (!rst_ni)
    rsp_i.r_valid && !req_i.r_ready |=> rsp_i.r_valid && $stable(rsp_i.r_data))
    else $error("rvalid or rdata changed before rready");

  tiler_valid_busy: assert property (@(posedge clk_int) disable iff (!rst_ni)
    tiler_valid_i |-> busy_i)
    else $error("tiler valid seen while the engine is not busy");

endmodule

`default_nettype wire

// File: tb/gemm_cfg_tb.sv
// Testbench for the GEMM configuration front end that runs random jobs against a model
`default_nettype none

`include "gemm_cfg_defines.svh"

module gemm_cfg_tb
  import gemm_cfg_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int clk_period    = 10;
  localparam int num_directed  = 4;
  localparam int num_jobs      = 40;
  localparam int job_cycles    = 200;
  // Reset and the register access checks before the jobs
  localparam int margin_cycles = 1000;

  logic      clk_int = 1'b0;
  logic      rst_ni;
  axil_req_t req;
  axil_rsp_t rsp;
  integer    seed = 32'h4b76;

  gemm_cfg_top dut_i (
    .clk_int    (clk_int),
    .rst_ni     (rst_ni),
    .axil_req_i (req),
    .axil_rsp_o (rsp)
  );

  bind gemm_cfg_regfile gemm_cfg_properties properties_i (
    .clk_int       (clk_int),
    .rst_ni        (rst_ni),
    .req_i         (axil_req_i),
    .rsp_i         (axil_rsp_o),
    .tiler_valid_i (valid_i),
    .busy_i        (busy_q)
  );

  always #(clk_period / 2) clk_int = ~clk_int;

  task automatic abort_run(input string reason);
    $display("test failed");
    $fatal(1, "%s", reason);
  endtask

  task automatic check_eq(input string what, input word_t got, input word_t exp);
    if (got !== exp) begin
      $display("ERROR at %0t ns: %s read %08h, expected %08h", $time, what, got, exp);
      abort_run("a value did not match the reference model");
    end
  endtask

  function automatic axil_addr_t reg_addr(input reg_idx_t idx);
    return {2'b00, idx, 2'b00};
  endfunction

  task automatic axil_write(input axil_addr_t addr, input word_t data, input axil_strb_t strb);
    int unsigned delay;
    @(negedge clk_int);
    req.aw_valid = 1'b1;
    req.aw_addr  = addr;
    req.w_valid  = 1'b1;
    req.w_data   = data;
    req.w_strb   = strb;
    // Both readies follow the valids within the cycle while no response is pending
    #(clk_period / 4);
    check_eq("awready and wready before the handshake",
             32'({rsp.aw_ready, rsp.w_ready}), 32'h3);
    // bvalid rising marks the address and data handshake
    do begin
      @(negedge clk_int);
    end while (!rsp.b_valid);
    check_eq("awready and wready after the handshake",
             32'({rsp.aw_ready, rsp.w_ready}), 32'h0);
    req.aw_valid = 1'b0;
    req.w_valid  = 1'b0;
    check_eq("write response", 32'(rsp.b_resp), 32'(axil_resp_okay));
    delay = $unsigned($random(seed)) % 4;
    repeat (delay) @(negedge clk_int);
    req.b_ready = 1'b1;
    @(negedge clk_int);
    req.b_ready = 1'b0;
  endtask

  task automatic axil_read(input axil_addr_t addr, output word_t data);
    int unsigned delay;
    @(negedge clk_int);
    req.ar_valid = 1'b1;
    req.ar_addr  = addr;
    // arready is up whenever no read response is pending
    #(clk_period / 4);
    check_eq("arready before the handshake", 32'(rsp.ar_ready), 32'h1);
    do begin
      @(negedge clk_int);
    end while (!rsp.r_valid);
    check_eq("arready while the response is pending", 32'(rsp.ar_ready), 32'h0);
    req.ar_valid = 1'b0;
    data = rsp.r_data;
    check_eq("read response", 32'(rsp.r_resp), 32'(axil_resp_okay));
    delay = $unsigned($random(seed)) % 4;
    repeat (delay) begin
      @(negedge clk_int);
      check_eq("read data while rready is low", rsp.r_data, data);
    end
    req.r_ready = 1'b1;
    @(negedge clk_int);
    req.r_ready = 1'b0;
  endtask

  function automatic word_t merge_bytes(input word_t old_data, input word_t new_data,
                                        input axil_strb_t strb);
    word_t merged;
    merged = old_data;
    for (int b = 0; b < $bits(axil_strb_t); b++) begin
      if (strb[b]) begin
        merged[8*b +: 8] = new_data[8*b +: 8];
      end
    end
    return merged;
  endfunction

  // Reference tiling straight from the array geometry
  function automatic tiler_res_t model_tiling(input dim_t m, input dim_t n, input dim_t k,
                                              input gemm_op_e op, input gemm_fmt_e fmt);
    tiler_res_t      res;
    longint unsigned mm;
    longint unsigned nn;
    longint unsigned kk;
    longint unsigned x_rows;
    longint unsigned x_cols;
    longint unsigned w_rows;
    longint unsigned w_cols;
    longint unsigned rows_cols;
    fpu_op_e         op1;
    mm = m;
    nn = n;
    kk = k;
    x_rows    = (mm + `GEMM_ARRAY_WIDTH - 1) / `GEMM_ARRAY_WIDTH;
    x_cols    = (nn + `GEMM_TILE_DEPTH - 1) / `GEMM_TILE_DEPTH;
    w_cols    = (kk + `GEMM_TILE_DEPTH - 1) / `GEMM_TILE_DEPTH;
    w_rows    = ((nn + `GEMM_ARRAY_HEIGHT - 1) / `GEMM_ARRAY_HEIGHT) * `GEMM_ARRAY_HEIGHT;
    rows_cols = (x_rows * w_cols) & 32'hffff_ffff;
    res.x_iters     = {16'(x_rows), 16'(x_cols)};
    res.w_iters     = {16'(w_rows), 16'(w_cols)};
    res.leftovers   = {8'(mm % `GEMM_ARRAY_WIDTH), 8'(nn % `GEMM_TILE_DEPTH),
                       8'(nn % `GEMM_ARRAY_HEIGHT), 8'(kk % `GEMM_TILE_DEPTH)};
    res.tot_stores  = {16'(rows_cols), 16'h0};
    res.x_d1_stride = 32'(nn * `GEMM_ELEM_BYTES);
    res.w_tot_len   = 32'(rows_cols * w_rows);
    res.tot_x_read  = 32'(rows_cols * x_cols);
    case (op)
      MATMUL, GEMM:   op1 = FPU_FMADD;
      ADDMAX, ADDMIN: op1 = FPU_ADD;
      MULMAX, MULMIN: op1 = FPU_MUL;
      default:        op1 = FPU_MINMAX;
    endcase
    res.op_sel        = '0;
    res.op_sel[31:29] = (op == MAXMIN) ? RTZ : RNE;
    res.op_sel[28:26] = (op == ADDMAX || op == MULMAX) ? RTZ : RNE;
    res.op_sel[25:21] = op1;
    res.op_sel[20:16] = FPU_MINMAX;
    res.op_sel[15:13] = fmt;
    res.op_sel[12:10] = fmt;
    res.op_sel[0]     = (op != MATMUL);
    return res;
  endfunction

  task automatic run_job(input int j);
    dim_t       m;
    dim_t       n;
    dim_t       k;
    gemm_op_e   op;
    gemm_fmt_e  fmt;
    word_t      macfg;
    word_t      data;
    tiler_res_t exp_res;
    // Corner sizes come first with no leftovers and with unit sizes
    case (j)
      0: {m, n, k} = {16'd1, 16'd1, 16'd1};
      1: {m, n, k} = {16'd12, 16'd16, 16'd16};
      2: {m, n, k} = {16'd1024, 16'd1024, 16'd1024};
      3: {m, n, k} = {16'd24, 16'd4, 16'd32};
      default: begin
        m = dim_t'(1 + $unsigned($random(seed)) % 1024);
        n = dim_t'(1 + $unsigned($random(seed)) % 1024);
        k = dim_t'(1 + $unsigned($random(seed)) % 1024);
      end
    endcase
    op  = (j < 7) ? gemm_op_e'(3'(j)) : gemm_op_e'(3'($unsigned($random(seed)) % 7));
    fmt = gemm_fmt_e'(3'($unsigned($random(seed)) % 4));
    macfg        = $random(seed);
    macfg[12:10] = op;
    macfg[9:7]   = fmt;
    axil_write(reg_addr(`GEMM_REG_X_ADDR), $random(seed), 4'hf);
    axil_write(reg_addr(`GEMM_REG_W_ADDR), $random(seed), 4'hf);
    axil_write(reg_addr(`GEMM_REG_Z_ADDR), $random(seed), 4'hf);
    axil_write(reg_addr(`GEMM_REG_MCFG0), {k, m}, 4'hf);
    axil_write(reg_addr(`GEMM_REG_MCFG1), {16'($random(seed)), n}, 4'hf);
    axil_write(reg_addr(`GEMM_REG_MACFG), macfg, 4'hf);
    axil_write(reg_addr(`GEMM_REG_TRIGGER), 32'h1, 4'h1);
    axil_read(reg_addr(`GEMM_REG_STATUS), data);
    check_eq($sformatf("status after trigger of job %0d", j), data, 32'h1);
    // Every fourth job retriggers with other sizes while the tiler is busy
    if (j % 4 == 3) begin
      axil_write(reg_addr(`GEMM_REG_MCFG0), {k + 16'd16, m + 16'd12}, 4'hf);
      axil_write(reg_addr(`GEMM_REG_TRIGGER), 32'h1, 4'hf);
    end
    data = '0;
    while (!data[1]) begin
      axil_read(reg_addr(`GEMM_REG_STATUS), data);
    end
    check_eq($sformatf("status at the end of job %0d", j), data, 32'h2);
    exp_res = model_tiling(m, n, k, op, fmt);
    for (int r = 0; r < 8; r++) begin
      axil_read(reg_addr(reg_idx_t'(`GEMM_REG_X_ITERS + r)), data);
      check_eq($sformatf("result register %0d of job %0d", `GEMM_REG_X_ITERS + r, j),
               data, exp_res[(7 - r) * 32 +: 32]);
    end
  endtask

  initial begin
    word_t      data;
    word_t      first;
    word_t      second;
    axil_strb_t strb;
    axil_addr_t high_bits;
    req    = '0;
    rst_ni = 1'b0;
    repeat (5) @(posedge clk_int);
    @(negedge clk_int);
    rst_ni = 1'b1;

    for (int r = 0; r < 16; r++) begin
      axil_read(reg_addr(reg_idx_t'(r)), data);
      check_eq($sformatf("register %0d after reset", r), data, '0);
    end

    // Job registers merge by byte strobe and ignore the upper address bits
    for (int r = 0; r < `GEMM_REG_TRIGGER; r++) begin
      first     = $random(seed);
      second    = $random(seed);
      strb      = axil_strb_t'($random(seed));
      high_bits = {2'($random(seed)), 6'b0};
      axil_write(reg_addr(reg_idx_t'(r)) | high_bits, first, 4'hf);
      axil_write(reg_addr(reg_idx_t'(r)), second, strb);
      axil_read(reg_addr(reg_idx_t'(r)) | high_bits, data);
      check_eq($sformatf("job register %0d readback", r), data,
               merge_bytes(first, second, strb));
    end
    for (int r = `GEMM_REG_STATUS; r < 16; r++) begin
      axil_write(reg_addr(reg_idx_t'(r)), $random(seed), 4'hf);
      axil_read(reg_addr(reg_idx_t'(r)), data);
      check_eq($sformatf("read-only register %0d after a write", r), data, '0);
    end

    for (int j = 0; j < num_directed + num_jobs; j++) begin
      run_job(j);
    end
    $display("test passed");
    $finish;
  end

  initial begin
    #((num_directed + num_jobs) * job_cycles * clk_period + margin_cycles * clk_period);
    abort_run("watchdog timeout, the jobs did not finish in the allowed time");
  end

endmodule

`default_nettype wire
